/* flist.f */
verilog/matchPkg.sv
verilog/pixelLogConverter.sv
verilog/descriptorStore.sv
verilog/patchCorrelator.sv
verilog/bestMatchTracker.sv
verilog/matcherTop.sv
sim/tbClock.sv
sim/tbMatcher.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tbMatcher
FLIST ?= flist.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= sim passed

SOURCES := $(shell cat $(FLIST))
SIMBIN := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIMBIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

test: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

/* sim/tbMatcher.sv */
`timescale 1ns/1ps

module tbMatcher;
	import matchPkg::*;

	localparam int periodNs = 20;
	localparam int maxGap = 3;
	localparam int patchPixels = beatsPerPatch * lanes;
	// 4 descriptors and 48 windows over all tests
	localparam int totalPatches = 52;
	localparam longint watchdogNs = longint'(totalPatches) * beatsPerPatch * (maxGap + 1)
		* periodNs + 1000 * periodNs;

	// expected tracker state after one windowDone
	typedef struct packed {
		logic signed [scoreWidth-1:0] score;
		logic [windowIndexWidth-1:0] index;
		logic lastOfSearch;
		logic [63:0] beatTime;
	} expectEntry;

	logic clk;
	logic rst;
	logic descValid;
	logic windowValid;
	rawGroup pixels;
	logic windowDone;
	logic searchDone;
	logic signed [scoreWidth-1:0] bestScore;
	logic [windowIndexWidth-1:0] bestIndex;

	int descPix [patchPixels];
	int winPix [patchPixels];
	int savedWin [patchPixels];
	// zeros, extremes and powers of two
	// 192 meets itself so the fractions sum to exactly 256
	int edgeVals [13] = '{0, -256, 255, 1, 2, 4, 8, 16, 32, 192, 128, -128, -1};
	expectEntry pending [$];
	int errorCount;
	int checkCount;
	// tracker model
	int modelCount;
	longint modelBest;
	int modelIndex;

	tbClock #(.periodNs(periodNs), .resetCycles(3)) clock0 (.clk(clk), .rst(rst));

	matcherTop dut0 (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.windowValid(windowValid),
		.pixels(pixels),
		.windowDone(windowDone),
		.searchDone(searchDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	function automatic int leadPos(input int mag);
		int pos;
		pos = 0;
		for (int b = 0; b < 9; b++) begin
			if (mag[b]) pos = b;
		end
		return pos;
	endfunction

	// log form of both pixels, then Mitchell antilog of the sum
	function automatic longint pixelProduct(input int a, input int b);
		int magA;
		int magB;
		int e;
		int s;
		longint mag;
		magA = (a < 0) ? -a : a;
		magB = (b < 0) ? -b : b;
		if (magA == 0 || magB == 0) return 0;
		e = leadPos(magA) + leadPos(magB);
		s = ((magA << (8 - leadPos(magA))) & 255) + ((magB << (8 - leadPos(magB))) & 255);
		if (s < 256) mag = (longint'(256 + s) << e) >> 8;
		else mag = (longint'(s) << (e + 1)) >> 8;
		return ((a < 0) != (b < 0)) ? -mag : mag;
	endfunction

	function automatic longint windowScore();
		longint sum;
		sum = 0;
		for (int i = 0; i < patchPixels; i++) sum += pixelProduct(winPix[i], descPix[i]);
		return sum;
	endfunction

	function automatic int randomPixel();
		return int'($urandom_range(511, 0)) - 256;
	endfunction

	task automatic reportMismatch(input string name, input longint expected, input longint actual);
		$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		errorCount++;
	endtask

	// update the tracker model and queue what windowDone should show
	task automatic expectWindow();
		expectEntry entry;
		longint score;
		score = windowScore();
		if (modelCount == 0 || (score < 0 ? -score : score) >
			(modelBest < 0 ? -modelBest : modelBest)) begin
			modelBest = score;
			modelIndex = modelCount;
		end
		entry.score = scoreWidth'(modelBest);
		entry.index = windowIndexWidth'(modelIndex);
		entry.lastOfSearch = (modelCount == windowsPerSearch - 1);
		entry.beatTime = $time;
		pending.push_back(entry);
		modelCount = (modelCount + 1) % windowsPerSearch;
	endtask

	// strobe stays up after the last beat so windows can follow back to back
	task automatic sendPatch(input logic isWindow, input int gapMax);
		int gap;
		for (int b = 0; b < beatsPerPatch; b++) begin
			gap = (gapMax > 0) ? int'($urandom_range(gapMax, 0)) : 0;
			repeat (gap) begin
				@(negedge clk);
				descValid = 1'b0;
				windowValid = 1'b0;
			end
			@(negedge clk);
			descValid = !isWindow;
			windowValid = isWindow;
			for (int lane = 0; lane < lanes; lane++) begin
				pixels.px[lane] = pixelWidth'(isWindow ? winPix[b * lanes + lane]
					: descPix[b * lanes + lane]);
			end
		end
		if (isWindow) expectWindow();
	endtask

	task automatic idleBus(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			descValid = 1'b0;
			windowValid = 1'b0;
		end
	endtask

	// outputs sampled on falling edges, well away from register updates
	initial begin : compareOutputs
		expectEntry head;
		forever begin
			@(negedge clk);
			if (!rst && windowDone) begin
				if (pending.size() == 0) begin
					$display("windowDone pulsed at %0t ns with no window outstanding", $time);
					errorCount++;
				end else begin
					head = pending.pop_front();
					checkCount++;
					if (bestScore !== head.score)
						reportMismatch("bestScore", head.score, bestScore);
					if (bestIndex !== head.index)
						reportMismatch("bestIndex", head.index, bestIndex);
					if (searchDone !== head.lastOfSearch)
						reportMismatch("searchDone", head.lastOfSearch, searchDone);
					if ($time - head.beatTime != 3 * periodNs)
						reportMismatch("windowDone latency ns", 3 * periodNs, $time - head.beatTime);
				end
			end else if (!rst && searchDone) begin
				$display("searchDone pulsed at %0t ns without windowDone", $time);
				errorCount++;
			end else if (pending.size() != 0 && $time - pending[0].beatTime > 3 * periodNs) begin
				$display("windowDone missing at %0t ns for a finished window", $time);
				errorCount++;
				void'(pending.pop_front());
			end
		end
	end

	initial begin : watchdog
		#(watchdogNs);
		$display("watchdog expired after %0d ns, run did not finish, errors %0d",
			watchdogNs, errorCount);
		$display("sim failed");
		$finish;
	end

	initial begin : runTests
		void'($urandom(32'h7011));
		descValid = 1'b0;
		windowValid = 1'b0;
		pixels = '0;
		errorCount = 0;
		checkCount = 0;
		modelCount = 0;
		modelBest = 0;
		modelIndex = 0;
		@(negedge clk);
		wait (!rst);
		@(negedge clk);

		// reset state
		checkCount++;
		if (windowDone !== 1'b0) reportMismatch("windowDone", 0, windowDone);
		if (searchDone !== 1'b0) reportMismatch("searchDone", 0, searchDone);
		if (bestScore !== '0) reportMismatch("bestScore", 0, bestScore);
		if (bestIndex !== '0) reportMismatch("bestIndex", 0, bestIndex);

		// random descriptor, one random window
		for (int i = 0; i < patchPixels; i++) descPix[i] = randomPixel();
		sendPatch(1'b0, 0);
		for (int i = 0; i < patchPixels; i++) winPix[i] = randomPixel();
		sendPatch(1'b1, 0);
		idleBus(4);

		// edge pixels in both patches, zero rule and both antilog branches
		for (int i = 0; i < patchPixels; i++) begin
			descPix[i] = edgeVals[i % 13];
			winPix[i] = edgeVals[(i * 5 + 3) % 13];
		end
		sendPatch(1'b0, 0);
		sendPatch(1'b1, 0);
		idleBus(4);

		// rest of the first search, every fourth window anti-correlated
		for (int i = 0; i < patchPixels; i++) descPix[i] = randomPixel();
		sendPatch(1'b0, 0);
		for (int w = 0; w < windowsPerSearch - 2; w++) begin
			for (int i = 0; i < patchPixels; i++) begin
				if (w % 4 == 1) winPix[i] = (descPix[i] == -256) ? 255 : -descPix[i];
				else winPix[i] = randomPixel();
			end
			if (w == 0) savedWin = winPix;
			sendPatch(1'b1, 0);
		end

		// next search opens with a weak window, then gaps and back-to-back beats
		for (int i = 0; i < patchPixels; i++) winPix[i] = (i == 0) ? 1 : 0;
		sendPatch(1'b1, 0);
		winPix = savedWin;
		sendPatch(1'b1, maxGap);
		for (int w = 2; w < windowsPerSearch; w++) begin
			for (int i = 0; i < patchPixels; i++) winPix[i] = randomPixel();
			sendPatch(1'b1, (w % 2 == 1) ? maxGap : 0);
		end
		idleBus(6);

		// new descriptor between searches
		for (int i = 0; i < patchPixels; i++) descPix[i] = randomPixel();
		sendPatch(1'b0, 2);
		idleBus(2);
		winPix = savedWin;
		sendPatch(1'b1, 1);
		for (int w = 1; w < windowsPerSearch; w++) begin
			for (int i = 0; i < patchPixels; i++) winPix[i] = randomPixel();
			sendPatch(1'b1, 1);
		end
		idleBus(8);

		if (pending.size() != 0) begin
			$display("%0d windows never got a windowDone", pending.size());
			errorCount++;
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* sim/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs = 20,
	parameter int resetCycles = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// release on a falling edge, clear of the flops' sampling edge
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* verilog/matcherTop.sv */
`timescale 1ns/1ps

module matcherTop (
	input logic clk,
	input logic rst,
	input logic descValid,
	input logic windowValid,
	input matchPkg::rawGroup pixels,
	output logic windowDone,
	output logic searchDone,
	output logic signed [matchPkg::scoreWidth-1:0] bestScore,
	output logic [matchPkg::windowIndexWidth-1:0] bestIndex
);
	import matchPkg::*;

	// converter outputs, shared by store and correlator
	logic logValid;
	logic logIsWindow;
	logGroup logPixels;

	// store read path
	logGroup descPixels;
	logic [beatIndexWidth-1:0] readIndex;

	// finished patch scores
	logic patchValid;
	logic signed [scoreWidth-1:0] patchScore;

	pixelLogConverter converter0 (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.windowValid(windowValid),
		.pixels(pixels),
		.logValid(logValid),
		.logIsWindow(logIsWindow),
		.logPixels(logPixels)
	);

	descriptorStore store0 (
		.clk(clk),
		.rst(rst),
		.logValid(logValid),
		.logIsWindow(logIsWindow),
		.logPixels(logPixels),
		.readIndex(readIndex),
		.descPixels(descPixels)
	);

	patchCorrelator correlator0 (
		.clk(clk),
		.rst(rst),
		.logValid(logValid),
		.logIsWindow(logIsWindow),
		.logPixels(logPixels),
		.descPixels(descPixels),
		.readIndex(readIndex),
		.patchValid(patchValid),
		.patchScore(patchScore)
	);

	bestMatchTracker tracker0 (
		.clk(clk),
		.rst(rst),
		.patchValid(patchValid),
		.patchScore(patchScore),
		.windowDone(windowDone),
		.searchDone(searchDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

endmodule

/* verilog/bestMatchTracker.sv */
`timescale 1ns/1ps

module bestMatchTracker (
	input logic clk,
	input logic rst,
	input logic patchValid,
	input logic signed [matchPkg::scoreWidth-1:0] patchScore,
	output logic windowDone,
	output logic searchDone,
	output logic signed [matchPkg::scoreWidth-1:0] bestScore,
	output logic [matchPkg::windowIndexWidth-1:0] bestIndex
);
	import matchPkg::*;

	logic [windowIndexWidth-1:0] windowCount;
	logic lastWindow;
	logic replaceBest;

	// unsigned magnitude, most negative score still fits
	function automatic logic [scoreWidth-1:0] absScore(input logic signed [scoreWidth-1:0] v);
		return v[scoreWidth-1] ? scoreWidth'(-v) : scoreWidth'(v);
	endfunction

	assign lastWindow = (windowCount == windowIndexWidth'(windowsPerSearch - 1));
	// window 0 loads outright, later ones must be strictly larger
	assign replaceBest = (windowCount == '0) || (absScore(patchScore) > absScore(bestScore));

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			windowCount <= '0;
			bestScore <= '0;
			bestIndex <= '0;
			windowDone <= 1'b0;
			searchDone <= 1'b0;
		end else begin
			windowDone <= patchValid;
			searchDone <= patchValid & lastWindow;
			if (patchValid) begin
				// wraps into the next search
				windowCount <= windowCount + 1'b1;
				if (replaceBest) begin
					bestScore <= patchScore;
					bestIndex <= windowCount;
				end
			end
		end
	end

	// each patch result is one pulse, counted as one window
	assert property (@(posedge clk) disable iff (rst) patchValid |=> !patchValid)
		else $error("patchValid high for more than one cycle");

endmodule

/* verilog/patchCorrelator.sv */
`timescale 1ns/1ps

module patchCorrelator (
	input logic clk,
	input logic rst,
	input logic logValid,
	input logic logIsWindow,
	input matchPkg::logGroup logPixels,
	input matchPkg::logGroup descPixels,
	output logic [matchPkg::beatIndexWidth-1:0] readIndex,
	output logic patchValid,
	output logic signed [matchPkg::scoreWidth-1:0] patchScore
);
	import matchPkg::*;

	logic [expWidth:0] expSum [lanes];
	logic [fracWidth:0] fracSum [lanes];
	logic [fracWidth+1:0] mantissa [lanes];
	logic [scoreWidth-1:0] magnitude [lanes];
	logic signed [scoreWidth-1:0] product [lanes];
	logic signed [scoreWidth-1:0] beatSum;
	logic signed [scoreWidth-1:0] accum;
	logic windowBeat;
	logic lastBeat;

	assign windowBeat = logValid & logIsWindow;
	assign lastBeat = windowBeat && (readIndex == beatIndexWidth'(beatsPerPatch - 1));

	// log add then antilog per lane
	always_comb begin
		beatSum = '0;
		for (int lane = 0; lane < lanes; lane++) begin
			expSum[lane] = {1'b0, logPixels.px[lane].exponent}
				+ {1'b0, descPixels.px[lane].exponent};
			fracSum[lane] = {1'b0, logPixels.px[lane].fraction}
				+ {1'b0, descPixels.px[lane].fraction};
			// s below 256 gives 256+s, otherwise 2s (carry into the exponent)
			mantissa[lane] = fracSum[lane][fracWidth] ? {fracSum[lane], 1'b0}
				: {2'b01, fracSum[lane][fracWidth-1:0]};
			// truncating shift back to integer
			magnitude[lane] = ({{(scoreWidth-fracWidth-2){1'b0}}, mantissa[lane]}
				<< expSum[lane]) >> fracWidth;
			if (logPixels.px[lane].isZero || descPixels.px[lane].isZero) begin
				product[lane] = '0;
			end else if (logPixels.px[lane].sign ^ descPixels.px[lane].sign) begin
				product[lane] = -signed'(magnitude[lane]);
			end else begin
				product[lane] = signed'(magnitude[lane]);
			end
			beatSum = beatSum + product[lane];
		end
	end

	// beat counter doubles as the store read address
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			readIndex <= '0;
			accum <= '0;
			patchValid <= 1'b0;
		end else begin
			patchValid <= lastBeat;
			if (windowBeat) begin
				readIndex <= readIndex + 1'b1;
				// restart at zero for the next window
				accum <= lastBeat ? '0 : accum + beatSum;
			end
		end
	end

	// finished sum, held while the next window streams in
	always_ff @(posedge clk) begin
		if (lastBeat) begin
			patchScore <= accum + beatSum;
		end
	end

endmodule

/* verilog/descriptorStore.sv */
`timescale 1ns/1ps

module descriptorStore (
	input logic clk,
	input logic rst,
	input logic logValid,
	input logic logIsWindow,
	input matchPkg::logGroup logPixels,
	input logic [matchPkg::beatIndexWidth-1:0] readIndex,
	output matchPkg::logGroup descPixels
);
	import matchPkg::*;

	// one log group per beat of the descriptor patch
	logGroup descMem [0:beatsPerPatch-1];
	logic [beatIndexWidth-1:0] writePtr;
	logic descWrite;

	assign descWrite = logValid & ~logIsWindow;

	// pointer wraps after 64 beats, so a reload starts at beat 0 again
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			writePtr <= '0;
		end else if (descWrite) begin
			writePtr <= writePtr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (descWrite) begin
			descMem[writePtr] <= logPixels;
		end
	end

	// zero latency read at the correlator's beat counter
	assign descPixels = descMem[readIndex];

	// descriptor beats only between windows, correlator counter at rest
	assert property (@(posedge clk) disable iff (rst) descWrite |-> (readIndex == '0))
		else $error("descriptor written while a window is in progress");

endmodule

/* verilog/pixelLogConverter.sv */
`timescale 1ns/1ps

module pixelLogConverter (
	input logic clk,
	input logic rst,
	input logic descValid,
	input logic windowValid,
	input matchPkg::rawGroup pixels,
	output logic logValid,
	output logic logIsWindow,
	output matchPkg::logGroup logPixels
);
	import matchPkg::*;

	logGroup nextPixels;

	// leading one by halving, zero input gives 0
	function automatic logic [expWidth-1:0] leadingOne(input logic [2*fracWidth-1:0] value);
		logic [2*fracWidth-1:0] probe;
		logic [expWidth-1:0] pos;
		probe = value;
		pos = '0;
		if (probe[15:8] != '0) begin
			pos = pos + expWidth'(8);
			probe = probe >> 8;
		end
		if (probe[7:4] != '0) begin
			pos = pos + expWidth'(4);
			probe = probe >> 4;
		end
		if (probe[3:2] != '0) begin
			pos = pos + expWidth'(2);
			probe = probe >> 2;
		end
		if (probe[1]) begin
			pos = pos + expWidth'(1);
		end
		return pos;
	endfunction

	always_comb begin : convertLanes
		logic [pixelWidth-1:0] magnitude;
		logic [expWidth-1:0] leadPos;
		logic [2*fracWidth-1:0] normalized;
		for (int lane = 0; lane < lanes; lane++) begin
			// -256 comes out as 9'h100, still fits unsigned
			magnitude = pixels.px[lane][pixelWidth-1] ? ~pixels.px[lane] + 1'b1 : pixels.px[lane];
			leadPos = leadingOne({{(2*fracWidth-pixelWidth){1'b0}}, magnitude});
			// leading one lands on bit 8, bits below it are the fraction
			normalized = {{(2*fracWidth-pixelWidth){1'b0}}, magnitude}
				<< (expWidth'(fracWidth) - leadPos);
			nextPixels.px[lane].isZero = (magnitude == '0);
			nextPixels.px[lane].sign = pixels.px[lane][pixelWidth-1];
			nextPixels.px[lane].exponent = leadPos;
			nextPixels.px[lane].fraction = normalized[fracWidth-1:0];
		end
	end

	// strobe and tag
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			logValid <= 1'b0;
			logIsWindow <= 1'b0;
		end else begin
			logValid <= descValid | windowValid;
			logIsWindow <= windowValid;
		end
	end

	// log group held until the next beat
	always_ff @(posedge clk) begin
		if (descValid || windowValid) begin
			logPixels <= nextPixels;
		end
	end

	// bus carries one patch kind per beat
	assert property (@(posedge clk) disable iff (rst) !(descValid && windowValid))
		else $error("descValid and windowValid high together");

endmodule

/* verilog/matchPkg.sv */
package matchPkg;

	// raw pixel bus
	localparam int pixelWidth = 9;
	localparam int lanes = 4;

	// 16x16 patch streamed four pixels per beat
	localparam int beatsPerPatch = 64;
	localparam int beatIndexWidth = 6;

	// log form of a pixel
	localparam int fracWidth = 8;
	// exponents 0 to 8 for magnitudes up to 256
	localparam int expWidth = 4;

	// score accumulator and search length
	localparam int scoreWidth = 32;
	localparam int windowsPerSearch = 16;
	localparam int windowIndexWidth = 4;

	// four signed pixels, lane 0 in the top bits
	typedef struct packed {
		logic [0:lanes-1][pixelWidth-1:0] px;
	} rawGroup;

	// one pixel in log form
	typedef struct packed {
		logic isZero;
		logic sign;
		logic [expWidth-1:0] exponent;
		logic [fracWidth-1:0] fraction;
	} logPixel;

	// four log pixels, same lane order as rawGroup
	typedef struct packed {
		logPixel [0:lanes-1] px;
	} logGroup;

endpackage
